// ==== cp0_params.svh ====
// MIPS32 CP0 field positions; BEV is fixed at one, so only the BEV=1 exception vector exists
`ifndef CP0_PARAMS_SVH
`define CP0_PARAMS_SVH

// Exception entry address with BEV set
`define EXC_VECTOR      32'hBFC0_0380

// Reset values
`define STATUS_RESET    32'h0040_0000   // BEV=1, IM/EXL/IE clear
`define COMPARE_RESET   32'hFFFF_FFFF   // Timer stays quiet until software programs Compare

// Status fields
`define STATUS_IE_BIT   0
`define STATUS_EXL_BIT  1
`define STATUS_IM_LO    8
`define STATUS_IM_HI    15
`define STATUS_WMASK    32'h0000_FF03   // IM7..0, EXL, IE

// Cause fields
`define CAUSE_EXC_LO    2
`define CAUSE_EXC_HI    6
`define CAUSE_IP_LO     8
`define CAUSE_IP_HI     15
`define CAUSE_TI_BIT    30
`define CAUSE_BD_BIT    31
`define CAUSE_WMASK     32'h0000_0300   // IP1..0 only

`endif

// ==== excPkg.sv ====
// Exception-side types; only the non-TLB subset of MIPS32 exception codes is present
`default_nettype none

package excPkg;

    // Cause.ExcCode values
    typedef enum logic [4:0] {
        excInt  = 5'h00,    // Interrupt
        excAdEL = 5'h04,    // Address error on fetch or load
        excAdES = 5'h05,    // Address error on store
        excSys  = 5'h08,
        excBp   = 5'h09,
        excRI   = 5'h0a,    // Reserved instruction
        excOv   = 5'h0c,
        excTr   = 5'h0d
    } excCodeE;

    // What the next-PC logic does with the MEM-stage instruction
    typedef enum logic [1:0] {
        redirNone      = 2'd0,  // Normal sequencing
        redirException = 2'd1,  // Jump to the exception vector
        redirEret      = 2'd2,  // Return to EPC
        redirRefetch   = 2'd3   // Restart at the faulting PC
    } redirectKindE;

endpackage

`default_nettype wire

// ==== cp0Pkg.sv ====
// CP0 register numbers for select 0 only; Config, PRId and TLB registers are absent
`default_nettype none

package cp0Pkg;

    // Register numbers as used by mtc0/mfc0
    typedef enum logic [4:0] {
        cp0BadVAddr = 5'd8,
        cp0Count    = 5'd9,
        cp0Compare  = 5'd11,
        cp0Status   = 5'd12,
        cp0Cause    = 5'd13,
        cp0Epc      = 5'd14
    } cp0RegE;

endpackage

`default_nettype wire

// ==== exceptionDetect.sv ====
// Combinational only; every input must describe the instruction sitting in MEM this cycle
`default_nettype none
`include "cp0_params.svh"

module exceptionDetect (
    input  logic [31:0]          memPc,
    input  logic                 memRegWrite,
    input  logic [31:0]          memBadAddr,
    input  logic                 memInDelaySlot,
    input  logic                 excReservedInstr,
    input  logic                 excSyscall,
    input  logic                 excBreak,
    input  logic                 excEret,
    input  logic                 excOverflow,
    input  logic                 excTrap,
    input  logic                 excLoadAddr,
    input  logic                 excStoreAddr,
    input  logic                 excRefetch,
    input  logic [7:0]           statusIm,
    input  logic                 statusExl,
    input  logic                 statusIe,
    input  logic [7:0]           causeIp,
    input  logic [31:0]          epc,
    output logic                 idFlush,
    output logic                 exeFlush,
    output logic                 memFlush,
    output logic                 regWriteFinal,
    output excPkg::redirectKindE redirectKind,
    output logic [31:0]          redirectPc,
    output logic                 takeException,
    output logic                 takeEret,
    output excPkg::excCodeE      excCode,
    output logic [31:0]          badVAddr,
    output logic                 badVAddrValid
);

    logic intPending;
    logic fetchAddrErr;
    logic anyException;
    logic anyEvent;

    assign intPending   = ((causeIp & statusIm) != 8'b0) && !statusExl && statusIe;
    assign fetchAddrErr = (memPc[1:0] != 2'b00);    // Misaligned fetch

    assign anyException = intPending | fetchAddrErr | excReservedInstr | excSyscall
                        | excBreak | excOverflow | excTrap | excLoadAddr | excStoreAddr;
    assign anyEvent     = anyException | excEret | excRefetch;

    // Redirect kind, flushes and write cancel
    always_comb begin
        if (anyEvent) begin
            if (excRefetch) begin
                redirectKind = excPkg::redirRefetch;
            end else if (excEret) begin
                redirectKind = excPkg::redirEret;
            end else begin
                redirectKind = excPkg::redirException;
            end
            idFlush       = 1'b1;
            exeFlush      = 1'b1;
            memFlush      = 1'b1;
            regWriteFinal = 1'b0;   // Faulting instruction must not retire its write
        end else begin
            redirectKind  = excPkg::redirNone;
            idFlush       = 1'b0;
            exeFlush      = 1'b0;
            memFlush      = 1'b0;
            regWriteFinal = memRegWrite;
        end
    end

    // Target address for the next-PC logic
    always_comb begin
        case (redirectKind)
            excPkg::redirRefetch:   redirectPc = memPc;
            excPkg::redirEret:      redirectPc = epc;
            excPkg::redirException: redirectPc = `EXC_VECTOR;
            default:                redirectPc = 32'h0;
        endcase
    end

    // Commit strobes for CP0 follow the chosen kind
    assign takeException = (redirectKind == excPkg::redirException);
    assign takeEret      = (redirectKind == excPkg::redirEret);

    // Cause priority, highest first
    always_comb begin
        excCode       = excPkg::excInt;
        badVAddr      = 32'h0;
        badVAddrValid = 1'b0;
        if (intPending) begin
            excCode = excPkg::excInt;
        end else if (fetchAddrErr) begin
            excCode       = excPkg::excAdEL;
            badVAddr      = memPc;      // Fetch fault reports the PC itself
            badVAddrValid = 1'b1;
        end else if (excReservedInstr) begin
            excCode = excPkg::excRI;
        end else if (excOverflow) begin
            excCode = excPkg::excOv;
        end else if (excTrap) begin
            excCode = excPkg::excTr;
        end else if (excSyscall) begin
            excCode = excPkg::excSys;
        end else if (excBreak) begin
            excCode = excPkg::excBp;
        end else if (excLoadAddr) begin
            excCode       = excPkg::excAdEL;
            badVAddr      = memBadAddr;
            badVAddrValid = 1'b1;
        end else if (excStoreAddr) begin
            excCode       = excPkg::excAdES;
            badVAddr      = memBadAddr;
            badVAddrValid = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== cp0Regs.sv ====
// With EXL set a new exception keeps EPC and Cause.BD; exception or eret drops a same-cycle mtc0
`default_nettype none
`include "cp0_params.svh"

module cp0Regs (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [5:0]           hwInt,
    input  logic                 cp0Wen,
    input  cp0Pkg::cp0RegE       cp0WAddr,
    input  logic [31:0]          cp0WData,
    input  logic [4:0]           cp0RAddr,
    input  logic                 takeException,
    input  logic                 takeEret,
    input  excPkg::excCodeE      excCode,
    input  logic [31:0]          memPc,
    input  logic                 memInDelaySlot,
    input  logic [31:0]          badVAddr,
    input  logic                 badVAddrValid,
    output logic [31:0]          cp0RData,
    output logic [7:0]           statusIm,
    output logic                 statusExl,
    output logic                 statusIe,
    output logic [7:0]           causeIp,
    output logic [31:0]          epc
);

    logic [31:0]     statusReg;
    logic            causeBd;
    excPkg::excCodeE causeExc;
    logic [1:0]      causeIpSw;     // Software interrupt bits IP1..0
    logic [5:0]      hwIntQ;        // Sampled hardware lines
    logic            timerInt;
    logic [31:0]     countReg;
    logic [31:0]     compareReg;
    logic [31:0]     epcReg;
    logic [31:0]     badVAddrReg;
    logic [31:0]     causeValue;
    logic [31:0]     causeWr;
    logic            wrCommit;
    logic            wrStatus;
    logic            wrCause;
    logic            wrEpc;
    logic            wrCount;
    logic            wrCompare;

    // Exception or eret in the same cycle wins over mtc0
    assign wrCommit  = cp0Wen && !takeException && !takeEret;
    assign wrStatus  = wrCommit && (cp0WAddr == cp0Pkg::cp0Status);
    assign wrCause   = wrCommit && (cp0WAddr == cp0Pkg::cp0Cause);
    assign wrEpc     = wrCommit && (cp0WAddr == cp0Pkg::cp0Epc);
    assign wrCount   = wrCommit && (cp0WAddr == cp0Pkg::cp0Count);
    assign wrCompare = wrCommit && (cp0WAddr == cp0Pkg::cp0Compare);

    // IP7 shares the timer with hardware line 5
    assign causeIp = {hwIntQ[5] | timerInt, hwIntQ[4:0], causeIpSw};

    always_comb begin
        causeValue = 32'h0;
        causeValue[`CAUSE_BD_BIT]                 = causeBd;
        causeValue[`CAUSE_TI_BIT]                 = timerInt;
        causeValue[`CAUSE_IP_HI:`CAUSE_IP_LO]     = causeIp;
        causeValue[`CAUSE_EXC_HI:`CAUSE_EXC_LO]   = causeExc;
    end

    assign causeWr = (causeValue & ~`CAUSE_WMASK) | (cp0WData & `CAUSE_WMASK);

    assign statusIm  = statusReg[`STATUS_IM_HI:`STATUS_IM_LO];
    assign statusExl = statusReg[`STATUS_EXL_BIT];
    assign statusIe  = statusReg[`STATUS_IE_BIT];
    assign epc       = epcReg;

    // Status
    always_ff @(posedge clk) begin
        if (!rstN) begin
            statusReg <= `STATUS_RESET;
        end else if (takeException) begin
            statusReg[`STATUS_EXL_BIT] <= 1'b1;
        end else if (takeEret) begin
            statusReg[`STATUS_EXL_BIT] <= 1'b0;
        end else if (wrStatus) begin
            statusReg <= (statusReg & ~`STATUS_WMASK) | (cp0WData & `STATUS_WMASK);
        end
    end

    // Cause
    always_ff @(posedge clk) begin
        if (!rstN) begin
            causeBd   <= 1'b0;
            causeExc  <= excPkg::excInt;
            causeIpSw <= 2'b00;
        end else if (takeException) begin
            if (!statusExl) begin
                causeBd <= memInDelaySlot;
            end
            causeExc <= excCode;
        end else if (wrCause) begin
            causeIpSw <= causeWr[`CAUSE_IP_LO +: 2];
        end
    end

    // EPC points at the branch when the fault is in its delay slot
    always_ff @(posedge clk) begin
        if (takeException && !statusExl) begin
            epcReg <= memInDelaySlot ? memPc - 32'd4 : memPc;
        end else if (wrEpc) begin
            epcReg <= cp0WData;
        end
    end

    always_ff @(posedge clk) begin
        if (takeException && badVAddrValid) begin
            badVAddrReg <= badVAddr;    // Read-only to software
        end
    end

    // One register stage on the interrupt lines
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hwIntQ <= 6'b0;
        end else begin
            hwIntQ <= hwInt;
        end
    end

    // Count runs every cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            countReg <= 32'h0;
        end else if (wrCount) begin
            countReg <= cp0WData;
        end else begin
            countReg <= countReg + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            compareReg <= `COMPARE_RESET;
        end else if (wrCompare) begin
            compareReg <= cp0WData;
        end
    end

    // Timer bit sets on match, clears on any Compare write
    always_ff @(posedge clk) begin
        if (!rstN) begin
            timerInt <= 1'b0;
        end else if (wrCompare) begin
            timerInt <= 1'b0;
        end else if (countReg == compareReg) begin
            timerInt <= 1'b1;
        end
    end

    // mfc0 read port
    always_comb begin
        case (cp0RAddr)
            cp0Pkg::cp0BadVAddr: cp0RData = badVAddrReg;
            cp0Pkg::cp0Count:    cp0RData = countReg;
            cp0Pkg::cp0Compare:  cp0RData = compareReg;
            cp0Pkg::cp0Status:   cp0RData = statusReg;
            cp0Pkg::cp0Cause:    cp0RData = causeValue;
            cp0Pkg::cp0Epc:      cp0RData = epcReg;
            default:             cp0RData = 32'h0;  // Unimplemented registers read zero
        endcase
    end

endmodule

`default_nettype wire

// ==== exceptionUnit.sv ====
// No handshakes; MEM-stage inputs are levels for this cycle and CP0 state updates at the next edge
`default_nettype none

module exceptionUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [31:0]          memPc,
    input  logic                 memInDelaySlot,
    input  logic                 memRegWrite,
    input  logic [31:0]          memBadAddr,
    input  logic                 excReservedInstr,
    input  logic                 excSyscall,
    input  logic                 excBreak,
    input  logic                 excEret,
    input  logic                 excOverflow,
    input  logic                 excTrap,
    input  logic                 excLoadAddr,
    input  logic                 excStoreAddr,
    input  logic                 excRefetch,
    input  logic [5:0]           hwInt,
    input  logic                 cp0Wen,
    input  cp0Pkg::cp0RegE       cp0WAddr,
    input  logic [31:0]          cp0WData,
    input  logic [4:0]           cp0RAddr,
    output logic                 idFlush,
    output logic                 exeFlush,
    output logic                 memFlush,
    output logic                 regWriteFinal,
    output excPkg::redirectKindE redirectKind,
    output logic [31:0]          redirectPc,
    output logic [31:0]          cp0RData
);

    logic [7:0]      statusIm;
    logic            statusExl;
    logic            statusIe;
    logic [7:0]      causeIp;
    logic [31:0]     epc;
    logic            takeException;
    logic            takeEret;
    excPkg::excCodeE excCode;
    logic [31:0]     badVAddr;
    logic            badVAddrValid;

    exceptionDetect exceptionDetect_i (
        .memPc(memPc),
        .memRegWrite(memRegWrite),
        .memBadAddr(memBadAddr),
        .memInDelaySlot(memInDelaySlot),
        .excReservedInstr(excReservedInstr),
        .excSyscall(excSyscall),
        .excBreak(excBreak),
        .excEret(excEret),
        .excOverflow(excOverflow),
        .excTrap(excTrap),
        .excLoadAddr(excLoadAddr),
        .excStoreAddr(excStoreAddr),
        .excRefetch(excRefetch),
        .statusIm(statusIm),
        .statusExl(statusExl),
        .statusIe(statusIe),
        .causeIp(causeIp),
        .epc(epc),
        .idFlush(idFlush),
        .exeFlush(exeFlush),
        .memFlush(memFlush),
        .regWriteFinal(regWriteFinal),
        .redirectKind(redirectKind),
        .redirectPc(redirectPc),
        .takeException(takeException),
        .takeEret(takeEret),
        .excCode(excCode),
        .badVAddr(badVAddr),
        .badVAddrValid(badVAddrValid)
    );

    // CP0 state feeds the detector back in the same cycle
    cp0Regs cp0Regs_i (
        .clk(clk),
        .rstN(rstN),
        .hwInt(hwInt),
        .cp0Wen(cp0Wen),
        .cp0WAddr(cp0WAddr),
        .cp0WData(cp0WData),
        .cp0RAddr(cp0RAddr),
        .takeException(takeException),
        .takeEret(takeEret),
        .excCode(excCode),
        .memPc(memPc),
        .memInDelaySlot(memInDelaySlot),
        .badVAddr(badVAddr),
        .badVAddrValid(badVAddrValid),
        .cp0RData(cp0RData),
        .statusIm(statusIm),
        .statusExl(statusExl),
        .statusIe(statusIe),
        .causeIp(causeIp),
        .epc(epc)
    );

endmodule

`default_nettype wire

// ==== tb_exceptionUnit.sv ====
// Run from the project root so exception_trace.txt is found; the first mismatch stops the run
`default_nettype none
`include "cp0_params.svh"

module tb_exceptionUnit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 3;
    localparam int FIELD_COUNT  = 18;
    localparam int MARGIN       = 10;   // Extra cycles allowed by the watchdog

    logic                 clk;
    logic                 rstN;
    logic [31:0]          memPc;
    logic                 memInDelaySlot;
    logic                 memRegWrite;
    logic [31:0]          memBadAddr;
    logic                 excReservedInstr;
    logic                 excSyscall;
    logic                 excBreak;
    logic                 excEret;
    logic                 excOverflow;
    logic                 excTrap;
    logic                 excLoadAddr;
    logic                 excStoreAddr;
    logic                 excRefetch;
    logic [5:0]           hwInt;
    logic                 cp0Wen;
    cp0Pkg::cp0RegE       cp0WAddr;
    logic [31:0]          cp0WData;
    logic [4:0]           cp0RAddr;
    logic                 idFlush;
    logic                 exeFlush;
    logic                 memFlush;
    logic                 regWriteFinal;
    excPkg::redirectKindE redirectKind;
    logic [31:0]          redirectPc;
    logic [31:0]          cp0RData;

    // Expected values of the current trace line
    logic                 expIdFlush;
    logic                 expExeFlush;
    logic                 expMemFlush;
    logic                 expRegWrite;
    excPkg::redirectKindE expKind;
    logic [31:0]          expRedirectPc;
    logic [31:0]          expRData;

    string traceLines[$];
    int    numLines;
    logic  traceLoaded;

    exceptionUnit exceptionUnit_i (
        .clk(clk),
        .rstN(rstN),
        .memPc(memPc),
        .memInDelaySlot(memInDelaySlot),
        .memRegWrite(memRegWrite),
        .memBadAddr(memBadAddr),
        .excReservedInstr(excReservedInstr),
        .excSyscall(excSyscall),
        .excBreak(excBreak),
        .excEret(excEret),
        .excOverflow(excOverflow),
        .excTrap(excTrap),
        .excLoadAddr(excLoadAddr),
        .excStoreAddr(excStoreAddr),
        .excRefetch(excRefetch),
        .hwInt(hwInt),
        .cp0Wen(cp0Wen),
        .cp0WAddr(cp0WAddr),
        .cp0WData(cp0WData),
        .cp0RAddr(cp0RAddr),
        .idFlush(idFlush),
        .exeFlush(exeFlush),
        .memFlush(memFlush),
        .regWriteFinal(regWriteFinal),
        .redirectKind(redirectKind),
        .redirectPc(redirectPc),
        .cp0RData(cp0RData)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic compareOutput(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("** Error at %0d ns: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    // Keeps data lines and skips comment lines that start with #
    task automatic readTrace(input int fd);
        string line;
        int    got;
        got = $fgets(line, fd);
        while (got != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                traceLines.push_back(line);
            end
            got = $fgets(line, fd);
        end
    endtask

    task automatic applyLine(input int lineNo, input string line);
        logic [31:0] pcVal;
        logic [31:0] badVal;
        logic [31:0] wDataVal;
        logic [31:0] rpcVal;
        logic [31:0] rDataVal;
        logic [8:0]  flagVal;
        logic [5:0]  hwVal;
        logic [4:0]  wAddrVal;
        logic [4:0]  rAddrVal;
        logic [1:0]  kindVal;
        logic        dsVal;
        logic        rwVal;
        logic        wenVal;
        logic        rndVal;
        logic        idVal;
        logic        exeVal;
        logic        memVal;
        logic        rwExpVal;
        int          got;
        got = $sscanf(line, "%h %b %b %h %b %b %b %h %h %h %b %b %b %b %b %h %h %h",
                      pcVal, dsVal, rwVal, badVal, flagVal, hwVal, wenVal, wAddrVal,
                      wDataVal, rAddrVal, rndVal, idVal, exeVal, memVal, rwExpVal,
                      kindVal, rpcVal, rDataVal);
        if (got != FIELD_COUNT) begin
            abortRun($sformatf("Trace data line %0d does not hold %0d fields",
                               lineNo, FIELD_COUNT));
        end else begin
            if (rndVal) begin   // Fields the DUT ignores on this line
                badVal   = $urandom;
                wDataVal = $urandom;
            end
            memPc          = pcVal;
            memInDelaySlot = dsVal;
            memRegWrite    = rwVal;
            memBadAddr     = badVal;
            {excReservedInstr, excSyscall, excBreak, excEret, excOverflow,
             excTrap, excLoadAddr, excStoreAddr, excRefetch} = flagVal;
            hwInt    = hwVal;
            cp0Wen   = wenVal;
            cp0WAddr = cp0Pkg::cp0RegE'(wAddrVal);
            cp0WData = wDataVal;
            cp0RAddr = rAddrVal;
            expIdFlush    = idVal;
            expExeFlush   = exeVal;
            expMemFlush   = memVal;
            expRegWrite   = rwExpVal;
            expKind       = excPkg::redirectKindE'(kindVal);
            expRedirectPc = rpcVal;
            expRData      = rDataVal;
        end
    endtask

    task automatic checkOutputs();
        compareOutput("idFlush", {31'b0, idFlush}, {31'b0, expIdFlush});
        compareOutput("exeFlush", {31'b0, exeFlush}, {31'b0, expExeFlush});
        compareOutput("memFlush", {31'b0, memFlush}, {31'b0, expMemFlush});
        compareOutput("regWriteFinal", {31'b0, regWriteFinal}, {31'b0, expRegWrite});
        compareOutput("redirectKind", {30'b0, redirectKind}, {30'b0, expKind});
        if (expKind == excPkg::redirException) begin
            compareOutput("redirectPc", redirectPc, `EXC_VECTOR);
        end else if (expKind == excPkg::redirRefetch) begin
            compareOutput("redirectPc", redirectPc, memPc);    // Restart at the MEM-stage PC
        end else begin
            compareOutput("redirectPc", redirectPc, expRedirectPc);
        end
        compareOutput("cp0RData", cp0RData, expRData);
    endtask

    initial begin : mainFlow
        int fd;
        int idx;
        rstN             = 1'b0;
        memPc            = 32'h0;
        memInDelaySlot   = 1'b0;
        memRegWrite      = 1'b0;
        memBadAddr       = 32'h0;
        excReservedInstr = 1'b0;
        excSyscall       = 1'b0;
        excBreak         = 1'b0;
        excEret          = 1'b0;
        excOverflow      = 1'b0;
        excTrap          = 1'b0;
        excLoadAddr      = 1'b0;
        excStoreAddr     = 1'b0;
        excRefetch       = 1'b0;
        hwInt            = 6'b0;
        cp0Wen           = 1'b0;
        cp0WAddr         = cp0Pkg::cp0Status;
        cp0WData         = 32'h0;
        cp0RAddr         = 5'd0;
        traceLoaded      = 1'b0;
        numLines         = 0;
        void'($urandom(32'h000150ff));
        fd = $fopen("exception_trace.txt", "r");
        if (fd == 0) begin
            abortRun("Could not open the trace file exception_trace.txt");
        end else begin
            readTrace(fd);
            $fclose(fd);
            numLines    = traceLines.size();
            traceLoaded = 1'b1;
            if (numLines == 0) begin
                abortRun("The trace file holds no data lines");
            end else begin
                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                rstN = 1'b1;
                for (idx = 0; idx < numLines; idx++) begin
                    applyLine(idx, traceLines[idx]);
                    @(posedge clk);
                    #(PERIOD / 2 - 1);  // Just before the next falling edge
                    checkOutputs();
                    @(negedge clk);
                end
                $display("=== PASS ===");
                $finish;
            end
        end
    end

    // Whole trace plus reset and a margin
    initial begin : watchdog
        wait (traceLoaded === 1'b1);
        #((numLines + RESET_CYCLES + MARGIN) * PERIOD);
        abortRun($sformatf("Timeout: the trace of %0d lines did not finish in time",
                           numLines));
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
excPkg.sv
cp0Pkg.sv
exceptionDetect.sv
cp0Regs.sv
exceptionUnit.sv
tb_exceptionUnit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_exceptionUnit
FILELIST  = build.f
PASS_MSG  = === PASS ===

.PHONY: sim clean

# Build and run; the status comes from the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F -x "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== exception_trace.txt ====
# pc ds rw badAddr flags(RI Sys Bp Eret Ov Tr LdA StA Ref) hwInt wen wAddr wData rAddr rnd
# expected: idFlush exeFlush memFlush regWriteFinal kind redirectPc cp0RData; rnd=1 randomizes badAddr and wData
00400000 0 1 00000000 000000000 000000 0 00 00000000 0c 1 0 0 0 1 0 00000000 00400000
00400004 0 1 00000000 000000000 000000 0 00 00000000 0d 1 0 0 0 1 0 00000000 00000000
00400008 0 0 00000000 000000000 000000 0 00 00000000 09 0 0 0 0 0 0 00000000 00000003
0040000c 0 1 00000000 000000000 000000 0 00 00000000 0b 0 0 0 0 1 0 00000000 ffffffff
00400010 0 1 00000000 100000000 000000 0 00 00000000 0d 0 1 1 1 0 1 bfc00380 00000028
00400014 0 1 00000000 000000000 000000 0 00 00000000 0e 0 0 0 0 1 0 00000000 00400010
00400018 0 0 00000000 000100000 000000 0 00 00000000 0c 0 1 1 1 0 2 00400010 00400000
00400020 1 1 00000000 010000000 000000 0 00 00000000 0d 0 1 1 1 0 1 bfc00380 80000020
00400024 0 1 00000000 000000000 000000 0 00 00000000 0e 0 0 0 0 1 0 00000000 0040001c
00400028 0 0 00000000 000100000 000000 0 00 00000000 0d 0 1 1 1 0 2 0040001c 80000020
00400030 0 1 00000000 001000000 000000 0 00 00000000 0d 0 1 1 1 0 1 bfc00380 00000024
00400034 0 0 00000000 000100000 000000 0 00 00000000 0e 0 1 1 1 0 2 00400030 00400030
00400040 0 1 00000000 000010000 000000 0 00 00000000 0d 0 1 1 1 0 1 bfc00380 00000030
00400044 0 1 00000000 000001000 000000 0 00 00000000 0e 0 1 1 1 0 1 bfc00380 00400040
00400048 0 0 00000000 000100000 000000 0 00 00000000 0d 0 1 1 1 0 2 00400040 00000034
00400050 0 1 10000003 000000100 000000 0 00 00000000 08 0 1 1 1 0 1 bfc00380 10000003
00400054 0 0 00000000 000100000 000000 0 00 00000000 0d 0 1 1 1 0 2 00400050 00000010
00400060 0 0 10000102 000000010 000000 0 00 00000000 08 0 1 1 1 0 1 bfc00380 10000102
00400064 0 0 00000000 000100000 000000 0 00 00000000 0d 0 1 1 1 0 2 00400060 00000014
00400072 0 1 00000000 000000000 000000 0 00 00000000 08 1 1 1 1 0 1 bfc00380 00400072
00400074 0 0 00000000 000100000 000000 0 00 00000000 0d 0 1 1 1 0 2 00400072 00000010
00400080 0 1 20000000 110010100 000000 0 00 00000000 0d 0 1 1 1 0 1 bfc00380 00000028
00400084 0 1 00000000 000000000 000000 0 00 00000000 08 1 0 0 0 1 0 00000000 00400072
00400088 0 0 00000000 000100000 000000 0 00 00000000 0c 0 1 1 1 0 2 00400080 00400000
00400091 0 1 30000000 010000010 000000 0 00 00000000 08 0 1 1 1 0 1 bfc00380 00400091
00400094 0 0 00000000 000100000 000000 0 00 00000000 0d 0 1 1 1 0 2 00400091 00000010
004000a0 0 1 00000000 000000001 000000 0 00 00000000 0c 1 1 1 1 0 3 004000a0 00400000
004000a8 1 1 00000000 000000001 000000 0 00 00000000 0e 0 1 1 1 0 3 004000a4 00400091
004000b0 0 1 00000000 000000000 000000 1 0c ffffffff 0c 0 0 0 0 1 0 00000000 0040ff03
004000b4 0 1 00000000 000000000 000001 0 00 00000000 0d 0 0 0 0 1 0 00000000 00000410
004000b8 0 1 00000000 000000000 000001 1 0c 0000ff01 0c 0 1 1 1 0 1 bfc00380 0040ff01
004000c0 0 1 00000000 000000000 000001 0 00 00000000 0d 0 0 0 0 1 0 00000000 00000400
004000c4 0 1 00000000 000000000 000000 0 00 00000000 0e 0 0 0 0 1 0 00000000 004000c0
004000c8 0 0 00000000 000100000 000000 0 00 00000000 0c 0 1 1 1 0 2 004000c0 0040ff01
004000d0 0 1 00000000 000000000 000000 1 0c 00000001 0c 0 0 0 0 1 0 00000000 00400001
004000d4 0 1 00000000 000000000 100000 0 00 00000000 0d 0 0 0 0 1 0 00000000 00008000
004000d8 0 1 00000000 000000000 000000 0 00 00000000 0d 0 0 0 0 1 0 00000000 00000000
004000dc 0 1 00000000 000000000 000000 1 0b 00000028 0b 0 0 0 0 1 0 00000000 00000028
00400100 0 1 00000000 000000000 000000 0 00 00000000 09 0 0 0 0 1 0 00000000 00000027
00400104 0 1 00000000 000000000 000000 0 00 00000000 0d 0 0 0 0 1 0 00000000 00000000
00400108 0 1 00000000 000000000 000000 0 00 00000000 0d 0 0 0 0 1 0 00000000 40008000
0040010c 0 1 00000000 000000000 000000 1 0d ffffffff 0d 0 0 0 0 1 0 00000000 40008300
00400110 0 1 00000000 000000000 000000 1 0b 00001000 0d 0 0 0 0 1 0 00000000 00000300
00400114 0 1 00000000 000000000 000000 1 0c 00000101 0c 0 1 1 1 0 1 bfc00380 00400101
00400124 1 1 00000000 000000000 000000 0 00 00000000 0e 0 0 0 0 1 0 00000000 00400120
00400128 0 0 00000000 000100000 000000 0 00 00000000 0d 0 1 1 1 0 2 00400120 80000300
00400130 0 1 00000000 000000000 000000 1 0d 00000000 0c 0 0 0 0 1 0 00000000 00400103
00400134 0 1 00000000 000000000 000000 0 00 00000000 0d 0 0 0 0 1 0 00000000 00000300
